//--- dv/stack_unit_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack unit testbench
// register and stack byte models, checked by assertions.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "stack_config.svh"

module stack_unit_tb;
    import cpu_regs_pkg::*;
    import stack_ops_pkg::*;

    logic        clk, rst, cen, go, reg_load, busy;
    logic        gaps;                          // cen drops out at random when set.
    stack_req_t  req;
    cpu_regs_t   load_val, regs, exp_regs, first_final;
    logic [7:0]  stack_model [1 << `STACK_AW];  // mirror of the stack RAM.
    logic [31:0] data_seed = 32'h9fb6;
    logic [31:0] cen_seed  = 32'h9fb6;
    int          exp_bytes = 0;
    int          byte_cnt = 0;                  // busy cycles with cen high.
    int          cycles = 0;
    int          cycle_limit = 200;             // grows by 40 per expected byte.
    string       test_name;

    stack_unit dut_i (.clk(clk), .rst(rst), .cen(cen), .req(req), .go(go),
                      .reg_load(reg_load), .load_val(load_val), .busy(busy), .regs(regs));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rand_word();
        data_seed = xorshift(data_seed);
        return data_seed;
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [95:0] expected,
                               input logic [95:0] actual);
        assert (expected == actual) else stop_with_error($sformatf(
            "ERROR %s: %s expected %h actual %h", test_name, what, expected, actual));
    endtask

    always @(posedge clk) begin
        if (cen && go && !busy) byte_cnt <= 0;  // an accepted request starts a new count.
        else if (cen && busy) byte_cnt <= byte_cnt + 1;
        cycles <= cycles + 1;
        if (cycles > cycle_limit) stop_with_error("timeout: the DUT did not go idle in time");
    end

    assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> regs == exp_regs)
        else stop_with_error($sformatf("ERROR %s: regs expected %h actual %h",
                                       test_name, exp_regs, regs));
    assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> byte_cnt == exp_bytes)
        else stop_with_error($sformatf("ERROR %s: bytes expected %0d actual %0d",
                                       test_name, exp_bytes, byte_cnt));
    assert property (@(posedge clk) disable iff (rst)
                     !$past(cen) |-> $stable(busy) && $stable(regs))
        else stop_with_error("busy or regs changed in a cycle with cen low");

    // 16-bit registers sit on postbyte bits 7 to 4.
    function automatic int byte_total(input logic [7:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) if (mask[i]) n = n + ((i >= 4) ? 2 : 1);
        return n;
    endfunction

    function automatic logic [15:0] read_field(input int bit_i, input logic use_u);
        case (bit_i)
            7: return exp_regs.pc;
            6: return use_u ? exp_regs.s : exp_regs.u;  // the stack not in use.
            5: return exp_regs.y;
            4: return exp_regs.x;
            3: return {8'h00, exp_regs.dp};
            2: return {8'h00, exp_regs.b};
            1: return {8'h00, exp_regs.a};
            default: return {8'h00, exp_regs.cc};
        endcase
    endfunction

    task automatic write_field(input int bit_i, input logic use_u, input logic [15:0] v);
        case (bit_i)
            7: exp_regs.pc = v;
            6: begin
                if (use_u) exp_regs.s = v;
                else exp_regs.u = v;
            end
            5: exp_regs.y = v;
            4: exp_regs.x = v;
            3: exp_regs.dp = v[7:0];
            2: exp_regs.b = v[7:0];
            1: exp_regs.a = v[7:0];
            default: exp_regs.cc = v[7:0];
        endcase
    endtask

    // predecrement, low byte first, so the high byte ends at the lower address.
    task automatic push_regs(input logic use_u, input logic [7:0] mask);
        logic [15:0] sp;
        logic [15:0] v;
        sp = use_u ? exp_regs.u : exp_regs.s;
        for (int i = 7; i >= 0; i--) begin
            if (mask[i]) begin
                v = read_field(i, use_u);
                sp = sp - 16'd1;
                stack_model[sp[`STACK_AW-1:0]] = v[7:0];
                if (i >= 4) begin
                    sp = sp - 16'd1;
                    stack_model[sp[`STACK_AW-1:0]] = v[15:8];
                end
            end
        end
        if (use_u) exp_regs.u = sp;
        else exp_regs.s = sp;
    endtask

    task automatic pull_regs(input logic use_u, input logic [7:0] mask);
        logic [15:0] sp;
        logic [15:0] v;
        sp = use_u ? exp_regs.u : exp_regs.s;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                v = 16'h0000;
                if (i >= 4) begin
                    v[15:8] = stack_model[sp[`STACK_AW-1:0]];  // high byte comes first.
                    sp = sp + 16'd1;
                end
                v[7:0] = stack_model[sp[`STACK_AW-1:0]];
                sp = sp + 16'd1;
                write_field(i, use_u, v);
            end
        end
        if (use_u) exp_regs.u = sp;
        else exp_regs.s = sp;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        go = 1'b0;
        reg_load = 1'b0;
        cen = 1'b1;
        if (gaps) begin
            cen_seed = xorshift(cen_seed);
            cen = (cen_seed[1:0] != 2'b00);  // low about one cycle in four.
        end
    endtask

    task automatic load_regs(input cpu_regs_t v);
        next_cycle();
        load_val = v;
        reg_load = 1'b1;
        cen = 1'b1;
        exp_regs = v;
        next_cycle();
        check_value("loaded regs", v, regs);
    endtask

    // new random values everywhere except the pointer that holds the stack.
    task automatic reload_keep_sp(input logic use_u);
        cpu_regs_t v;
        v = {rand_word(), rand_word(), rand_word()};
        if (use_u) v.u = exp_regs.u;
        else v.s = exp_regs.s;
        load_regs(v);
    endtask

    task automatic issue(input stack_op_e op, input logic [7:0] pb, input logic extra_go);
        logic [7:0] m;
        case (op)
            op_pshs, op_pshu: push_regs(op == op_pshu, pb);
            op_puls, op_pulu: pull_regs(op == op_pulu, pb);
            default: ;
        endcase
        exp_bytes = byte_total(pb);
        if (op == op_int) begin
            m = exp_regs.cc[CC_E] ? 8'hff : 8'h81;
            push_regs(1'b0, m);
            exp_bytes = byte_total(m);
        end else if (op == op_rti) begin
            pull_regs(1'b0, 8'h01);
            m = exp_regs.cc[CC_E] ? 8'hfe : 8'h80;  // decided by the pulled E bit.
            pull_regs(1'b0, m);
            exp_bytes = 1 + byte_total(m);
        end
        cycle_limit = cycle_limit + 40 * exp_bytes;
        next_cycle();
        req.op = op;
        req.postbyte = pb;
        go = 1'b1;
        cen = 1'b1;
        next_cycle();
        if (extra_go) begin
            req.op = op_pulu;                  // lands while busy and must be dropped.
            req.postbyte = 8'hff;
            go = 1'b1;
            cen = 1'b1;
        end
        while (busy) next_cycle();
        next_cycle();                          // let the end-of-transfer checks sample.
    endtask

    task automatic run_sequence();
        cpu_regs_t  start;
        logic [7:0] pb;
        for (int n = 0; n < 4; n++) begin
            test_name = "pshs_puls";
            start = {rand_word(), rand_word(), rand_word()};
            load_regs(start);
            pb = 8'(rand_word());
            issue(op_pshs, pb, 1'b0);
            reload_keep_sp(1'b0);
            issue(op_puls, pb, 1'b0);
            check_value("s", 96'(start.s), 96'(regs.s));
            test_name = "pshu_pulu";
            start = {rand_word(), rand_word(), rand_word()};
            load_regs(start);
            pb = 8'(rand_word()) | 8'h40;      // s travels on the u stack.
            issue(op_pshu, pb, 1'b0);
            reload_keep_sp(1'b1);
            issue(op_pulu, pb, 1'b0);
            check_value("s", 96'(start.s), 96'(regs.s));
        end
        for (int e = 1; e >= 0; e--) begin
            test_name = (e == 1) ? "int_rti_full" : "int_rti_short";
            start = {rand_word(), rand_word(), rand_word()};
            start.cc[CC_E] = (e == 1);
            load_regs(start);
            issue(op_int, 8'h00, 1'b0);
            check_value("s", 96'(start.s - ((e == 1) ? 16'd12 : 16'd3)), 96'(regs.s));
            reload_keep_sp(1'b0);
            issue(op_rti, 8'h00, 1'b0);
            check_value("s", 96'(start.s), 96'(regs.s));
        end
        test_name = "ignored_go";
        issue(op_puls, 8'h00, 1'b0);
        check_value("regs", exp_regs, regs);
        issue(op_pshs, 8'hff, 1'b1);
        issue(op_puls, 8'hff, 1'b0);
    endtask

    initial begin
        rst = 1'b1;
        cen = 1'b0;
        go = 1'b0;
        reg_load = 1'b0;
        req = '0;
        load_val = '0;
        gaps = 1'b0;
        exp_regs = '0;
        test_name = "reset";
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!busy) else stop_with_error("busy is high after reset");
        check_value("regs", 96'd0, regs);
        run_sequence();
        first_final = exp_regs;                // model state at the end of the no-gap run.
        gaps = 1'b1;
        data_seed = 32'h9fb6;                  // same data again, now with cen gaps.
        run_sequence();
        test_name = "cen_gaps";
        check_value("final regs", first_final, regs);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+verilog
verilog/cpu_regs_pkg.sv
verilog/stack_ops_pkg.sv
verilog/stack_seq.sv
verilog/stack_addr.sv
verilog/cpu_regfile.sv
verilog/stack_ram.sv
verilog/stack_unit.sv
dv/stack_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps -f project.f --top-module stack_unit_tb
out=$(./obj_dir/Vstack_unit_tb 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qxF "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

//--- verilog/cpu_regfile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu register file
// nine registers with a whole-set load port, a byte
// write-back port and a stack pointer update port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "stack_config.svh"

module cpu_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    reg_load,
    input  cpu_regs_pkg::cpu_regs_t load_val,
    input  logic                    wb_en,
    input  cpu_regs_pkg::reg_sel_e  wb_sel,
    input  logic                    wb_hi,
    input  logic [`REG8_W-1:0]      wb_data,
    input  logic                    ptr_en,
    input  logic                    ptr_u,
    input  logic [`REG16_W-1:0]     ptr_val,
    output cpu_regs_pkg::cpu_regs_t regs
);
    import cpu_regs_pkg::*;

    // replaces one byte of a 16-bit register.
    function automatic logic [`REG16_W-1:0] put_byte(
        input logic [`REG16_W-1:0] word,
        input logic                hi,
        input logic [`REG8_W-1:0]  data
    );
        logic [`REG16_W-1:0] res;
        res = word;
        if (hi) begin
            res[`REG16_W-1 -: `REG8_W] = data;
        end else begin
            res[`REG8_W-1:0] = data;
        end
        return res;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '0;
        end else if (cen) begin
            if (reg_load) begin
                regs <= load_val;            // stands in for alu write-back.
            end else begin
                if (ptr_en) begin
                    if (ptr_u) regs.u <= ptr_val;
                    else       regs.s <= ptr_val;
                end
                // Placed after the pointer step so a byte aimed at the same pointer wins.
                if (wb_en) begin
                    case (wb_sel)
                        sel_pc: regs.pc <= put_byte(regs.pc, wb_hi, wb_data);
                        sel_sp: begin
                            if (ptr_u) regs.s <= put_byte(regs.s, wb_hi, wb_data);
                            else       regs.u <= put_byte(regs.u, wb_hi, wb_data);
                        end
                        sel_y:  regs.y  <= put_byte(regs.y, wb_hi, wb_data);
                        sel_x:  regs.x  <= put_byte(regs.x, wb_hi, wb_data);
                        sel_dp: regs.dp <= wb_data;
                        sel_b:  regs.b  <= wb_data;
                        sel_a:  regs.a  <= wb_data;
                        default: regs.cc <= wb_data;
                    endcase
                end
            end
        end
    end

endmodule

//--- verilog/cpu_regs_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// programmer-visible register set
// register struct, condition code flags and the
// postbyte register selector.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "stack_config.svh"

package cpu_regs_pkg;

    typedef struct packed {
        logic [`REG16_W-1:0] pc;       // program counter.
        logic [`REG16_W-1:0] u;        // user stack pointer.
        logic [`REG16_W-1:0] s;        // hardware stack pointer.
        logic [`REG16_W-1:0] y;        // index register y.
        logic [`REG16_W-1:0] x;        // index register x.
        logic [`REG8_W-1:0]  dp;       // direct page.
        logic [`REG8_W-1:0]  b;        // accumulator b.
        logic [`REG8_W-1:0]  a;        // accumulator a.
        logic [`REG8_W-1:0]  cc;       // condition codes.
    } cpu_regs_t;

    localparam int CC_E = 7;           // entire state was stacked.
    localparam int CC_F = 6;           // firq mask.
    localparam int CC_I = 4;           // irq mask.

    // each value equals its bit position in the postbyte.
    typedef enum logic [2:0] {
        sel_cc = 3'd0,
        sel_a  = 3'd1,
        sel_b  = 3'd2,
        sel_dp = 3'd3,
        sel_x  = 3'd4,
        sel_y  = 3'd5,
        sel_sp = 3'd6,                 // the stack pointer that is not in use.
        sel_pc = 3'd7
    } reg_sel_e;

endpackage

//--- verilog/stack_addr.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack address and byte pick stage
// forms the RAM address, the byte to store and the
// register and pointer write-back for one transfer.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "stack_config.svh"

module stack_addr (
    input  stack_ops_pkg::byte_xfer_t xfer,
    input  cpu_regs_pkg::cpu_regs_t   regs,
    input  logic [`REG8_W-1:0]        rdata,
    output logic [`STACK_AW-1:0]      addr,
    output logic [`REG8_W-1:0]        wdata,
    output logic                      we,
    output logic                      wb_en,
    output cpu_regs_pkg::reg_sel_e    wb_sel,
    output logic                      wb_hi,
    output logic [`REG8_W-1:0]        wb_data,
    output logic                      ptr_en,
    output logic                      ptr_u,
    output logic [`REG16_W-1:0]       ptr_val,
    output logic [`REG8_W-1:0]        cc_pulled
);
    import cpu_regs_pkg::*;

    logic [`REG16_W-1:0] sp;           // pointer of the active stack.
    logic [`REG16_W-1:0] other_sp;     // the pointer that bit 6 names.
    logic [`REG16_W-1:0] sp_dec;
    logic [`REG16_W-1:0] sp_inc;
    logic [`REG16_W-1:0] src_word;     // selected register, 8-bit ones zero extended.
    logic                wide;         // selected register is 16 bits.

    always_comb begin
        if (xfer.use_u) begin
            sp       = regs.u;
            other_sp = regs.s;
        end else begin
            sp       = regs.s;
            other_sp = regs.u;
        end
    end

    always_comb begin
        wide     = 1'b1;
        src_word = regs.pc;
        case (xfer.sel)
            sel_pc: src_word = regs.pc;
            sel_sp: src_word = other_sp;     // pshs stores u, pshu stores s.
            sel_y:  src_word = regs.y;
            sel_x:  src_word = regs.x;
            sel_dp: begin
                wide     = 1'b0;
                src_word = {{`REG8_W{1'b0}}, regs.dp};
            end
            sel_b: begin
                wide     = 1'b0;
                src_word = {{`REG8_W{1'b0}}, regs.b};
            end
            sel_a: begin
                wide     = 1'b0;
                src_word = {{`REG8_W{1'b0}}, regs.a};
            end
            default: begin
                wide     = 1'b0;
                src_word = {{`REG8_W{1'b0}}, regs.cc};
            end
        endcase
    end

    assign sp_dec = sp - 1'b1;
    assign sp_inc = sp + 1'b1;

    // a push predecrements, a pull reads at the pointer and then steps up.
    assign addr    = xfer.push ? sp_dec[`STACK_AW-1:0] : sp[`STACK_AW-1:0];
    assign ptr_val = xfer.push ? sp_dec : sp_inc;
    assign ptr_en  = xfer.valid;       // every byte moves the pointer by one.
    assign ptr_u   = xfer.use_u;

    assign wdata = (wide && xfer.hi) ? src_word[`REG16_W-1 -: `REG8_W]
                                     : src_word[`REG8_W-1:0];
    assign we    = xfer.valid && xfer.push;

    assign wb_en   = xfer.valid && !xfer.push;  // pulls land in the register file.
    assign wb_sel  = xfer.sel;
    assign wb_hi   = wide && xfer.hi;
    assign wb_data = rdata;

    // The sequencer looks at this only while the cc byte of an rti is out.
    assign cc_pulled = (xfer.sel == sel_cc) ? rdata : regs.cc;

endmodule

//--- verilog/stack_config.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack unit build parameters
// sizes of the stack RAM and of the register set.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef STACK_CONFIG_SVH
`define STACK_CONFIG_SVH

// the stack pointers are always 16 bits, only the low bits reach the RAM.
`define STACK_AW 8

// width of PC, U, S, Y and X.
`define REG16_W 16

// width of DP, B, A, CC and of one stack byte.
`define REG8_W 8

`endif

//--- verilog/stack_ops_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack operation types
// opcodes, the request word and the per-byte
// transfer descriptor of the push/pull engine.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stack_ops_pkg;

    typedef enum logic [2:0] {
        op_pshs,                       // push onto s.
        op_pshu,                       // push onto u.
        op_puls,                       // pull from s.
        op_pulu,                       // pull from u.
        op_int,                        // interrupt entry on s.
        op_rti                         // return from interrupt on s.
    } stack_op_e;

    typedef struct packed {
        stack_op_e  op;                // what to do.
        logic [7:0] postbyte;          // registers to move, ignored by op_int and op_rti.
    } stack_req_t;

    // One of these is presented for every byte that crosses the stack.
    typedef struct packed {
        cpu_regs_pkg::reg_sel_e sel;   // register being moved.
        logic                   hi;    // high byte of a 16-bit register.
        logic                   push;  // register file to stack when set.
        logic                   use_u; // u is the active stack.
        logic                   valid; // a byte moves this cycle.
    } byte_xfer_t;

endpackage

//--- verilog/stack_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack RAM
// byte-wide memory, clocked write, async read.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "stack_config.svh"

module stack_ram (
    input  logic                 clk,
    input  logic                 cen,
    input  logic [`STACK_AW-1:0] addr,
    input  logic [`REG8_W-1:0]   wdata,
    input  logic                 we,
    output logic [`REG8_W-1:0]   rdata
);

    localparam int DEPTH = 1 << `STACK_AW;  // 256 bytes with the default width.

    logic [`REG8_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (cen && we) begin
            mem[addr] <= wdata;          // push bytes land on the enabled edge.
        end
    end

    assign rdata = mem[addr];            // pulls see the byte in the same cycle.

endmodule

//--- verilog/stack_seq.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack push/pull sequencer
// walks the pending register mask one byte per
// enabled cycle, with the two-phase rti.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "stack_config.svh"

module stack_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  stack_ops_pkg::stack_req_t req,
    input  logic                      go,
    input  logic [`REG8_W-1:0]        cc,
    input  logic [`REG8_W-1:0]        cc_pulled,
    output stack_ops_pkg::byte_xfer_t xfer,
    output logic                      busy
);
    import cpu_regs_pkg::*;
    import stack_ops_pkg::*;

    typedef enum logic [1:0] {ph_idle, ph_move, ph_rti_cc, ph_rti_rest} phase_e;

    phase_e     phase;
    logic [7:0] mask;                  // registers still to be moved.
    logic       byte2;                 // second byte of a 16-bit register is due.
    logic       push;
    logic       use_u;
    logic [2:0] pick;                  // postbyte bit served this cycle.
    logic       last;                  // this cycle finishes the picked register.
    logic [7:0] cleared;
    logic [7:0] start_mask;

    // pushes go from bit 7 down, pulls from bit 0 up.
    always_comb begin
        pick = 3'd0;
        if (push) begin
            for (int i = 0; i < 8; i++) begin
                if (mask[i]) pick = 3'(i);  // the loop ends on the highest set bit.
            end
        end else begin
            for (int i = 7; i >= 0; i--) begin
                if (mask[i]) pick = 3'(i);  // the loop ends on the lowest set bit.
            end
        end
    end

    assign last    = !pick[2] || byte2;  // bits 7 to 4 are the 16-bit registers.
    assign cleared = mask & ~(8'h01 << pick);
    assign busy    = (phase != ph_idle);

    always_comb begin
        case (req.op)
            op_int:  start_mask = cc[CC_E] ? 8'hff : 8'h81;  // everything, or pc and cc.
            op_rti:  start_mask = 8'h01;                      // cc comes back first.
            default: start_mask = req.postbyte;
        endcase
    end

    always_comb begin
        xfer.sel   = reg_sel_e'(pick);
        xfer.hi    = push ? byte2 : !byte2;  // pushes store the low byte first.
        xfer.push  = push;
        xfer.use_u = use_u;
        xfer.valid = busy;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= ph_idle;
            mask  <= '0;
            byte2 <= 1'b0;
            push  <= 1'b0;
            use_u <= 1'b0;
        end else if (cen) begin
            if (phase == ph_idle) begin
                if (go) begin
                    mask  <= start_mask;
                    byte2 <= 1'b0;
                    push  <= (req.op == op_pshs) || (req.op == op_pshu) || (req.op == op_int);
                    use_u <= (req.op == op_pshu) || (req.op == op_pulu);
                    if (req.op == op_rti) begin
                        phase <= ph_rti_cc;
                    end else if (start_mask != 8'h00) begin
                        phase <= ph_move;    // an empty postbyte never leaves idle.
                    end
                end
            end else if (!last) begin
                byte2 <= 1'b1;               // same register, other byte next.
            end else begin
                byte2 <= 1'b0;
                if (phase == ph_rti_cc) begin
                    mask  <= cc_pulled[CC_E] ? 8'hfe : 8'h80;  // rest follows with no gap.
                    phase <= ph_rti_rest;
                end else begin
                    mask <= cleared;
                    if (cleared == 8'h00) phase <= ph_idle;
                end
            end
        end
    end

endmodule

//--- verilog/stack_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack push/pull engine
// sequencer, address stage, register file and RAM.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "stack_config.svh"

module stack_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  stack_ops_pkg::stack_req_t req,
    input  logic                      go,
    input  logic                      reg_load,
    input  cpu_regs_pkg::cpu_regs_t   load_val,
    output logic                      busy,
    output cpu_regs_pkg::cpu_regs_t   regs
);
    import cpu_regs_pkg::*;
    import stack_ops_pkg::*;

    byte_xfer_t           xfer;        // byte being moved this cycle.
    logic [`REG8_W-1:0]   cc_pulled;
    logic [`STACK_AW-1:0] addr;
    logic [`REG8_W-1:0]   wdata;
    logic                 we;
    logic [`REG8_W-1:0]   rdata;
    logic                 wb_en;
    reg_sel_e             wb_sel;
    logic                 wb_hi;
    logic [`REG8_W-1:0]   wb_data;
    logic                 ptr_en;
    logic                 ptr_u;
    logic [`REG16_W-1:0]  ptr_val;

    stack_seq seq_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .req       (req),
        .go        (go),
        .cc        (regs.cc),
        .cc_pulled (cc_pulled),
        .xfer      (xfer),
        .busy      (busy)
    );

    stack_addr addr_i (
        .xfer      (xfer),
        .regs      (regs),
        .rdata     (rdata),
        .addr      (addr),
        .wdata     (wdata),
        .we        (we),
        .wb_en     (wb_en),
        .wb_sel    (wb_sel),
        .wb_hi     (wb_hi),
        .wb_data   (wb_data),
        .ptr_en    (ptr_en),
        .ptr_u     (ptr_u),
        .ptr_val   (ptr_val),
        .cc_pulled (cc_pulled)
    );

    cpu_regfile regfile_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .reg_load  (reg_load),
        .load_val  (load_val),
        .wb_en     (wb_en),
        .wb_sel    (wb_sel),
        .wb_hi     (wb_hi),
        .wb_data   (wb_data),
        .ptr_en    (ptr_en),
        .ptr_u     (ptr_u),
        .ptr_val   (ptr_val),
        .regs      (regs)
    );

    stack_ram ram_i (
        .clk       (clk),
        .cen       (cen),
        .addr      (addr),
        .wdata     (wdata),
        .we        (we),
        .rdata     (rdata)
    );

endmodule
